// ==== verilog/board_pkg.sv ====
package board_pkg;

    // Board GPIO and lane counts
    localparam int NUM_LANES    = 4;
    localparam int NUM_BUTTONS  = 5;
    localparam int NUM_SWITCHES = 4;
    localparam int LED_WIDTH    = 8;

    // Buttons and switches share one debouncer
    localparam int NUM_GPIO_INPUTS = NUM_BUTTONS + NUM_SWITCHES;

    // Synchronizer depths
    localparam int RESET_SYNC_DEPTH = 4;
    localparam int INPUT_SYNC_DEPTH = 2;

    // Debounce sample period and history depth
    localparam int DEBOUNCE_RATE  = 156;
    localparam int DEBOUNCE_DEPTH = 4;
    localparam int DEBOUNCE_CNT_W = $clog2(DEBOUNCE_RATE);

    typedef logic [DEBOUNCE_CNT_W-1:0] debounce_cnt_t;

    // One bit per QSFP lane, lane 0 in bit 0
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef logic [LED_WIDTH-1:0] led_t;

endpackage

// ==== verilog/sgmii_pkg.sv ====
package sgmii_pkg;

    // PCS/PMA status vector
    localparam int STATUS_WIDTH = 16;

    typedef logic [STATUS_WIDTH-1:0] sgmii_status_t;

    // Bit positions used by the decoder
    //   [0]     link status
    //   [1]     link synchronization
    //   [2..7]  RUDI and code group flags, not decoded here
    //   [9:8]   remote fault encoding, not decoded here
    //   [11:10] speed
    //   [12]    duplex
    //   [15:13] remote fault and pause, not decoded here
    localparam int LINK_STATUS_BIT = 0;
    localparam int LINK_SYNC_BIT   = 1;
    localparam int SPEED_LSB       = 10;
    localparam int SPEED_WIDTH     = 2;
    localparam int DUPLEX_BIT      = 12;

    // Speed code as reported by the core
    typedef enum logic [SPEED_WIDTH-1:0] {
        SPEED_10   = 2'd0,
        SPEED_100  = 2'd1,
        SPEED_1000 = 2'd2
    } sgmii_speed_e;

    // Decoded link state, link_up in the top bit
    typedef struct packed {
        logic         link_up;
        logic         link_sync;
        sgmii_speed_e speed;
        logic         full_duplex;
    } sgmii_link_t;

endpackage

// ==== verilog/board_gpio_if.sv ====
`timescale 1ns/1ps

interface board_gpio_if;

    // Debounced push buttons
    logic btn_u;
    logic btn_l;
    logic btn_d;
    logic btn_r;
    logic btn_c;

    // Debounced slide switches
    logic [board_pkg::NUM_SWITCHES-1:0] sw;

    modport producer (
        output btn_u, btn_l, btn_d, btn_r, btn_c,
        output sw
    );

    // LED source select only looks at the switches
    modport consumer (
        input sw
    );

endinterface

// ==== verilog/gpio_input_cond.sv ====
`timescale 1ns/1ps

module gpio_input_cond (
    input  logic                               gt_rxusrclk,
    input  logic                               gt_tx_reset,
    input  logic [board_pkg::NUM_BUTTONS-1:0]  btn_i,
    input  logic [board_pkg::NUM_SWITCHES-1:0] sw_i,
    input  logic                               uart_rxd_i,
    input  logic                               uart_cts_i,
    board_gpio_if.producer                     gpio,
    output logic                               uart_rxd_o,
    output logic                               uart_cts_o
);

    // Buttons in the upper bits (u, l, d, r, c) and switches below
    logic [board_pkg::NUM_GPIO_INPUTS-1:0] raw_in;
    logic [board_pkg::NUM_GPIO_INPUTS-1:0] deb_q;
    logic [board_pkg::NUM_GPIO_INPUTS-1:0][board_pkg::DEBOUNCE_DEPTH-1:0] sample_hist;

    board_pkg::debounce_cnt_t rate_cnt;
    logic                     sample_stb;

    logic [board_pkg::INPUT_SYNC_DEPTH-1:0] rxd_sync;
    logic [board_pkg::INPUT_SYNC_DEPTH-1:0] cts_sync;

    assign raw_in     = {btn_i, sw_i};
    assign sample_stb = (rate_cnt == board_pkg::debounce_cnt_t'(board_pkg::DEBOUNCE_RATE - 1));

    // Sample strobe once per DEBOUNCE_RATE clocks
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rate_cnt <= '0;
        end else if (sample_stb) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            sample_hist <= '0;
            deb_q       <= '0;
        end else begin
            for (int i = 0; i < board_pkg::NUM_GPIO_INPUTS; i++) begin
                if (sample_stb) begin
                    sample_hist[i] <= {sample_hist[i][board_pkg::DEBOUNCE_DEPTH-2:0], raw_in[i]};
                end
                // Output moves only once every stored sample agrees
                if (&sample_hist[i]) begin
                    deb_q[i] <= 1'b1;
                end else if (~|sample_hist[i]) begin
                    deb_q[i] <= 1'b0;
                end
            end
        end
    end

    assign {gpio.btn_u, gpio.btn_l, gpio.btn_d, gpio.btn_r, gpio.btn_c} =
        deb_q[board_pkg::NUM_SWITCHES +: board_pkg::NUM_BUTTONS];
    assign gpio.sw = deb_q[board_pkg::NUM_SWITCHES-1:0];

    // UART lines idle high while in reset
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rxd_sync <= '1;
            cts_sync <= '1;
        end else begin
            rxd_sync <= {rxd_sync[board_pkg::INPUT_SYNC_DEPTH-2:0], uart_rxd_i};
            cts_sync <= {cts_sync[board_pkg::INPUT_SYNC_DEPTH-2:0], uart_cts_i};
        end
    end

    assign uart_rxd_o = rxd_sync[board_pkg::INPUT_SYNC_DEPTH-1];
    assign uart_cts_o = cts_sync[board_pkg::INPUT_SYNC_DEPTH-1];

endmodule

// ==== verilog/gt_reset_seq.sv ====
`timescale 1ns/1ps

module gt_reset_seq (
    input  logic                  gt_rxusrclk,
    input  logic                  gt_tx_reset,
    input  logic                  gt_reset_tx_done_i,
    input  logic                  gt_reset_rx_done_i,
    input  board_pkg::lane_mask_t rxpmaresetdone_i,
    output logic                  userclk_tx_active_o,
    output logic                  userclk_rx_active_o,
    output logic                  core_rst_o,
    output logic                  rx_rst_o
);

    // Channel 0 is the core reset, channel 1 the receive reset
    logic [1:0]                                  rst_done;
    logic [1:0][board_pkg::RESET_SYNC_DEPTH-1:0] rst_chain;
    logic [1:0]                                  rst_out;
    logic                                        rx_active_q;
    logic                                        all_lanes_done;

    assign rst_done       = {gt_reset_rx_done_i, gt_reset_tx_done_i};
    assign all_lanes_done = &rxpmaresetdone_i;

    // User clock active flags
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            userclk_tx_active_o <= 1'b0;
            rx_active_q         <= 1'b0;
        end else begin
            userclk_tx_active_o <= 1'b1;
            rx_active_q         <= all_lanes_done;
        end
    end

    // Drops in the same cycle a lane loses PMA reset done
    assign userclk_rx_active_o = rx_active_q & all_lanes_done;

    // Reset chains reload while done is low, then shift zeros toward the output
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rst_chain <= '1;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!rst_done[i]) begin
                    rst_chain[i] <= '1;
                end else begin
                    rst_chain[i] <= {rst_chain[i][board_pkg::RESET_SYNC_DEPTH-2:0], 1'b0};
                end
            end
        end
    end

    // Assert right away on a falling done, release after the full chain
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rst_out[i] = rst_chain[i][board_pkg::RESET_SYNC_DEPTH-1] | ~rst_done[i];
        end
    end

    assign core_rst_o = rst_out[0];
    assign rx_rst_o   = rst_out[1];

    // Core must never leave reset in the cycle after tx done was low
    a_core_rst_after_done_low: assert property (
        @(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        !gt_reset_tx_done_i |=> core_rst_o
    ) else $error("core_rst_o low one cycle after gt_reset_tx_done_i was low");

endmodule

// ==== verilog/sgmii_link_status.sv ====
`timescale 1ns/1ps

module sgmii_link_status (
    input  logic                    gt_rxusrclk,
    input  logic                    gt_tx_reset,
    input  sgmii_pkg::sgmii_status_t pcspma_status_i,
    input  board_pkg::lane_mask_t   block_lock_i,
    input  board_pkg::led_t         core_led_i,
    board_gpio_if.consumer          gpio,
    output sgmii_pkg::sgmii_link_t  link_o,
    output logic                    speed_is_10_100_o,
    output logic                    speed_is_100_o,
    output board_pkg::led_t         led_o
);

    sgmii_pkg::sgmii_speed_e speed_code;
    sgmii_pkg::sgmii_link_t  link_d;
    board_pkg::led_t         led_d;

    assign speed_code = sgmii_pkg::sgmii_speed_e'(
        pcspma_status_i[sgmii_pkg::SPEED_LSB +: sgmii_pkg::SPEED_WIDTH]);

    // Unpack the status fields the board cares about
    always_comb begin
        link_d.link_up     = pcspma_status_i[sgmii_pkg::LINK_STATUS_BIT];
        link_d.link_sync   = pcspma_status_i[sgmii_pkg::LINK_SYNC_BIT];
        link_d.speed       = speed_code;
        link_d.full_duplex = pcspma_status_i[sgmii_pkg::DUPLEX_BIT];
    end

    // Switch 0 shows lane block lock instead of the core LEDs
    assign led_d = gpio.sw[0] ? board_pkg::led_t'(block_lock_i) : core_led_i;

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            link_o            <= '0;
            speed_is_10_100_o <= 1'b0;
            speed_is_100_o    <= 1'b0;
            led_o             <= '0;
        end else begin
            link_o            <= link_d;
            // Anything but gigabit runs the core at the slow rates
            speed_is_10_100_o <= (speed_code != sgmii_pkg::SPEED_1000);
            speed_is_100_o    <= (speed_code == sgmii_pkg::SPEED_100);
            led_o             <= led_d;
        end
    end

    // The 100M select is only meaningful in 10/100 mode
    a_speed_100_in_slow_mode: assert property (
        @(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        speed_is_100_o |-> speed_is_10_100_o
    ) else $error("speed_is_100_o set without speed_is_10_100_o");

endmodule

// ==== verilog/board_glue_top.sv ====
`timescale 1ns/1ps

module board_glue_top (
    input  logic                               gt_rxusrclk,
    input  logic                               gt_tx_reset,
    // Buttons ordered u, l, d, r, c from the top bit down
    input  logic [board_pkg::NUM_BUTTONS-1:0]  btn_i,
    input  logic [board_pkg::NUM_SWITCHES-1:0] sw_i,
    input  logic                               uart_rxd_i,
    input  logic                               uart_cts_i,
    input  logic                               gt_reset_tx_done_i,
    input  logic                               gt_reset_rx_done_i,
    input  board_pkg::lane_mask_t              rxpmaresetdone_i,
    input  board_pkg::lane_mask_t              block_lock_i,
    input  board_pkg::led_t                    core_led_i,
    input  sgmii_pkg::sgmii_status_t           pcspma_status_i,
    output logic [board_pkg::NUM_BUTTONS-1:0]  btn_o,
    output logic [board_pkg::NUM_SWITCHES-1:0] sw_o,
    output logic                               uart_rxd_o,
    output logic                               uart_cts_o,
    output logic                               userclk_tx_active_o,
    output logic                               userclk_rx_active_o,
    output logic                               core_rst_o,
    output logic                               rx_rst_o,
    output sgmii_pkg::sgmii_link_t             link_o,
    output logic                               speed_is_10_100_o,
    output logic                               speed_is_100_o,
    output board_pkg::led_t                    led_o
);

    board_gpio_if gpio_if ();

    gpio_input_cond i_gpio_input_cond (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .btn_i       (btn_i),
        .sw_i        (sw_i),
        .uart_rxd_i  (uart_rxd_i),
        .uart_cts_i  (uart_cts_i),
        .gpio        (gpio_if),
        .uart_rxd_o  (uart_rxd_o),
        .uart_cts_o  (uart_cts_o)
    );

    gt_reset_seq i_gt_reset_seq (
        .gt_rxusrclk         (gt_rxusrclk),
        .gt_tx_reset         (gt_tx_reset),
        .gt_reset_tx_done_i  (gt_reset_tx_done_i),
        .gt_reset_rx_done_i  (gt_reset_rx_done_i),
        .rxpmaresetdone_i    (rxpmaresetdone_i),
        .userclk_tx_active_o (userclk_tx_active_o),
        .userclk_rx_active_o (userclk_rx_active_o),
        .core_rst_o          (core_rst_o),
        .rx_rst_o            (rx_rst_o)
    );

    sgmii_link_status i_sgmii_link_status (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .pcspma_status_i   (pcspma_status_i),
        .block_lock_i      (block_lock_i),
        .core_led_i        (core_led_i),
        .gpio              (gpio_if),
        .link_o            (link_o),
        .speed_is_10_100_o (speed_is_10_100_o),
        .speed_is_100_o    (speed_is_100_o),
        .led_o             (led_o)
    );

    // Debounced GPIO back out to the pins
    assign btn_o = {gpio_if.btn_u, gpio_if.btn_l, gpio_if.btn_d, gpio_if.btn_r, gpio_if.btn_c};
    assign sw_o  = gpio_if.sw;

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD   = 50;
    localparam int RESET_CYCLES  = 5;
    localparam int RELEASE_DELAY = 10;

    // 100 ns clock
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset held for five rising edges and released in the drive phase
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #RELEASE_DELAY;
        rst_o = 1'b0;
    end

endmodule

// ==== verification/tb_board_glue.sv ====
`timescale 1ns/1ps

module tb_board_glue;

    localparam int DRIVE_DELAY    = 10;
    localparam int NUM_ROWS       = 6;
    localparam int UART_BITS      = 32;
    localparam int RESET_TIMEOUT  = 20;
    localparam int RELEASE_CLOCKS = 4;
    localparam int DEB_TIMEOUT    = 6 * board_pkg::DEBOUNCE_RATE;
    localparam int PULSE_CLOCKS   = 20;
    localparam int QUIET_CLOCKS   = 5 * board_pkg::DEBOUNCE_RATE;
    // The last row settled one clock after a sample strobe, so this lead
    // centres the pulse on the next strobe
    localparam int PULSE_LEAD     = board_pkg::DEBOUNCE_RATE - 3 - PULSE_CLOCKS / 2;

    typedef struct packed {
        logic [board_pkg::NUM_BUTTONS-1:0]  btn;
        logic [board_pkg::NUM_SWITCHES-1:0] sw;
        board_pkg::lane_mask_t              lock;
        logic [1:0]                         speed;
        logic                               exp_10_100;
        logic                               exp_100;
    } table_row_t;

    logic                               gt_rxusrclk;
    logic                               gt_tx_reset;
    logic [board_pkg::NUM_BUTTONS-1:0]  btn_i;
    logic [board_pkg::NUM_SWITCHES-1:0] sw_i;
    logic                               uart_rxd_i;
    logic                               uart_cts_i;
    logic                               gt_reset_tx_done_i;
    logic                               gt_reset_rx_done_i;
    board_pkg::lane_mask_t              rxpmaresetdone_i;
    board_pkg::lane_mask_t              block_lock_i;
    board_pkg::led_t                    core_led_i;
    sgmii_pkg::sgmii_status_t           pcspma_status_i;
    logic [board_pkg::NUM_BUTTONS-1:0]  btn_o;
    logic [board_pkg::NUM_SWITCHES-1:0] sw_o;
    logic                               uart_rxd_o;
    logic                               uart_cts_o;
    logic                               userclk_tx_active_o;
    logic                               userclk_rx_active_o;
    logic                               core_rst_o;
    logic                               rx_rst_o;
    sgmii_pkg::sgmii_link_t             link_o;
    logic                               speed_is_10_100_o;
    logic                               speed_is_100_o;
    board_pkg::led_t                    led_o;

    integer seed = 32'h104f;

    // Button and switch pattern, lane lock, speed code, expected speed levels
    table_row_t stim_table [NUM_ROWS] = '{
        '{5'b10000, 4'b0001, 4'b1010, 2'd0, 1'b1, 1'b0},
        '{5'b01000, 4'b0000, 4'b0110, 2'd1, 1'b1, 1'b1},
        '{5'b00101, 4'b1011, 4'b1111, 2'd2, 1'b0, 1'b0},
        '{5'b00010, 4'b0110, 4'b0001, 2'd3, 1'b1, 1'b0},
        '{5'b11111, 4'b1111, 4'b0101, 2'd2, 1'b0, 1'b0},
        '{5'b00000, 4'b0000, 4'b1100, 2'd1, 1'b1, 1'b1}
    };

    tb_clk_gen i_tb_clk_gen (
        .clk_o (gt_rxusrclk),
        .rst_o (gt_tx_reset)
    );

    board_glue_top i_board_glue_top (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_logic(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                                        $time, what, expected, actual));
        end
    endtask

    task automatic check_led(input board_pkg::led_t actual, input board_pkg::led_t expected,
                             input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                        $time, what, expected, actual));
        end
    endtask

    task automatic check_link(input sgmii_pkg::sgmii_link_t actual,
                              input sgmii_pkg::sgmii_link_t expected, input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                                        $time, what, expected, actual));
        end
    endtask

    task automatic check_gpio(input logic [board_pkg::NUM_BUTTONS-1:0] btn_exp,
                              input logic [board_pkg::NUM_SWITCHES-1:0] sw_exp,
                              input string what);
        if (btn_o !== btn_exp || sw_o !== sw_exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b/%b got %b/%b",
                                        $time, what, btn_exp, sw_exp, btn_o, sw_o));
        end
    endtask

    // Wait for the rising edge and move into the drive phase
    task automatic next_cycle();
        @(posedge gt_rxusrclk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (gt_tx_reset !== 1'b0) begin
            if (cycles == RESET_TIMEOUT) begin
                stop_with_failure("Timeout: gt_tx_reset was never released");
            end
            @(posedge gt_rxusrclk);
            cycles++;
        end
        #DRIVE_DELAY;
    endtask

    task automatic wait_for_debounce(input logic [board_pkg::NUM_BUTTONS-1:0] btn_exp,
                                     input logic [board_pkg::NUM_SWITCHES-1:0] sw_exp);
        int cycles;
        cycles = 0;
        while (btn_o !== btn_exp || sw_o !== sw_exp) begin
            if (cycles == DEB_TIMEOUT) begin
                stop_with_failure($sformatf("Timeout: debounced outputs never reached %b/%b",
                                            btn_exp, sw_exp));
            end
            next_cycle();
            cycles++;
        end
    endtask

    // Raises one done input and follows its reset for the release count
    task automatic release_reset(input bit rx_side);
        if (rx_side) begin
            gt_reset_rx_done_i = 1'b1;
        end else begin
            gt_reset_tx_done_i = 1'b1;
        end
        for (int k = 1; k <= RELEASE_CLOCKS; k++) begin
            next_cycle();
            check_logic(rx_side ? rx_rst_o : core_rst_o, k < RELEASE_CLOCKS,
                        $sformatf("%s reset %0d clocks after done", rx_side ? "rx" : "core", k));
        end
    endtask

    function automatic sgmii_pkg::sgmii_link_t expected_link(input sgmii_pkg::sgmii_status_t st);
        sgmii_pkg::sgmii_link_t lk;
        lk.link_up     = st[sgmii_pkg::LINK_STATUS_BIT];
        lk.link_sync   = st[sgmii_pkg::LINK_SYNC_BIT];
        lk.speed       = sgmii_pkg::sgmii_speed_e'(st[sgmii_pkg::SPEED_LSB +: 2]);
        lk.full_duplex = st[sgmii_pkg::DUPLEX_BIT];
        return lk;
    endfunction

    initial begin
        table_row_t               row;
        logic [31:0]              rnd;
        sgmii_pkg::sgmii_status_t status;
        logic                     rxd_d1;
        logic                     rxd_d2;
        logic                     cts_d1;
        logic                     cts_d2;

        btn_i              = '0;
        sw_i               = '0;
        uart_rxd_i         = 1'b1;
        uart_cts_i         = 1'b1;
        gt_reset_tx_done_i = 1'b0;
        gt_reset_rx_done_i = 1'b0;
        rxpmaresetdone_i   = '0;
        block_lock_i       = '0;
        core_led_i         = '0;
        pcspma_status_i    = '0;

        // Values while reset is held
        next_cycle();
        check_logic(core_rst_o, 1'b1, "core_rst_o in reset");
        check_logic(rx_rst_o, 1'b1, "rx_rst_o in reset");
        check_logic(userclk_tx_active_o, 1'b0, "userclk_tx_active_o in reset");
        check_logic(userclk_rx_active_o, 1'b0, "userclk_rx_active_o in reset");
        check_link(link_o, '0, "link_o in reset");
        check_led(led_o, '0, "led_o in reset");
        check_logic(speed_is_10_100_o, 1'b0, "speed_is_10_100_o in reset");
        check_logic(speed_is_100_o, 1'b0, "speed_is_100_o in reset");

        wait_reset_release();
        check_logic(userclk_tx_active_o, 1'b1, "userclk_tx_active_o after reset");
        check_logic(core_rst_o, 1'b1, "core_rst_o after reset");
        check_logic(rx_rst_o, 1'b1, "rx_rst_o after reset");
        check_logic(userclk_rx_active_o, 1'b0, "userclk_rx_active_o after reset");
        check_link(link_o, '0, "link_o after reset");
        check_led(led_o, '0, "led_o after reset");

        // Core reset release, drop and second release
        release_reset(1'b0);
        check_logic(rx_rst_o, 1'b1, "rx_rst_o while only tx done is high");
        gt_reset_tx_done_i = 1'b0;
        #1;
        check_logic(core_rst_o, 1'b1, "core_rst_o right after tx done falls");
        next_cycle();
        release_reset(1'b0);
        release_reset(1'b1);

        // Receive user clock active flag
        rxpmaresetdone_i = 4'b0111;
        next_cycle();
        check_logic(userclk_rx_active_o, 1'b0, "userclk_rx_active_o with three lanes done");
        rxpmaresetdone_i = 4'b1111;
        #1;
        check_logic(userclk_rx_active_o, 1'b0, "userclk_rx_active_o before the next edge");
        next_cycle();
        check_logic(userclk_rx_active_o, 1'b1, "userclk_rx_active_o with all lanes done");
        rxpmaresetdone_i = 4'b1011;
        #1;
        check_logic(userclk_rx_active_o, 1'b0, "userclk_rx_active_o after a lane drops");
        next_cycle();
        rxpmaresetdone_i = 4'b1111;
        next_cycle();
        check_logic(userclk_rx_active_o, 1'b1, "userclk_rx_active_o after lane recovers");

        // UART lines lag their inputs by two clocks
        rxd_d1 = uart_rxd_i;
        rxd_d2 = uart_rxd_i;
        cts_d1 = uart_cts_i;
        cts_d2 = uart_cts_i;
        for (int n = 0; n < UART_BITS; n++) begin
            check_logic(uart_rxd_o, rxd_d2, $sformatf("uart_rxd_o bit %0d", n));
            check_logic(uart_cts_o, cts_d2, $sformatf("uart_cts_o bit %0d", n));
            rnd        = $random(seed);
            uart_rxd_i = rnd[0];
            uart_cts_i = rnd[1];
            rxd_d2     = rxd_d1;
            rxd_d1     = rnd[0];
            cts_d2     = cts_d1;
            cts_d1     = rnd[1];
            next_cycle();
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row   = stim_table[r];
            btn_i = row.btn;
            sw_i  = row.sw;
            wait_for_debounce(row.btn, row.sw);

            rnd    = $random(seed);
            status = rnd[sgmii_pkg::STATUS_WIDTH-1:0];
            status[sgmii_pkg::SPEED_LSB +: 2] = row.speed;
            pcspma_status_i = status;
            block_lock_i    = row.lock;
            rnd             = $random(seed);
            core_led_i      = rnd[board_pkg::LED_WIDTH-1:0];
            next_cycle();

            check_link(link_o, expected_link(status), $sformatf("row %0d link_o", r));
            check_logic(speed_is_10_100_o, row.exp_10_100,
                        $sformatf("row %0d speed_is_10_100_o", r));
            check_logic(speed_is_100_o, row.exp_100, $sformatf("row %0d speed_is_100_o", r));
            check_led(led_o, row.sw[0] ? board_pkg::led_t'(row.lock) : core_led_i,
                      $sformatf("row %0d led_o", r));
        end

        // Pulse on every pin that spans one sample strobe and nothing more
        for (int n = 0; n < PULSE_LEAD + PULSE_CLOCKS + QUIET_CLOCKS; n++) begin
            if (n == PULSE_LEAD) begin
                btn_i = '1;
                sw_i  = '1;
            end else if (n == PULSE_LEAD + PULSE_CLOCKS) begin
                btn_i = '0;
                sw_i  = '0;
            end
            next_cycle();
            check_gpio('0, '0, "debounced outputs around short pulse");
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/board_pkg.sv
verilog/sgmii_pkg.sv
verilog/board_gpio_if.sv
verilog/gpio_input_cond.sv
verilog/gt_reset_seq.sv
verilog/sgmii_link_status.sv
verilog/board_glue_top.sv
verification/tb_clk_gen.sv
verification/tb_board_glue.sv

// ==== Bender.yml ====
package:
  name: board_glue

sources:
  # Packages first, then the interface and the blocks
  - files:
      - verilog/board_pkg.sv
      - verilog/sgmii_pkg.sv
      - verilog/board_gpio_if.sv
      - verilog/gpio_input_cond.sv
      - verilog/gt_reset_seq.sv
      - verilog/sgmii_link_status.sv
      - verilog/board_glue_top.sv

  # Testbench
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_board_glue.sv
